//--- logic/RenamePkg.sv
package RenamePkg;

    // Architectural register index
    typedef logic [4:0] ArchReg_t;

    // Physical register tag, 64 tags in the register file
    typedef logic [5:0] PhysTag_t;

    // Source tag as issue sees it
    // Top bit set means no physical register behind it
    typedef logic [6:0] SrcTag_t;

    // Sequence number, ordered by signed difference so it may wrap
    typedef logic [6:0] SqN_t;

    // Life cycle of a physical tag
    typedef enum logic [1:0] {
        TagFree,
        TagSpeculative,
        TagCommitted
    } TagState_e;

    localparam int NumArchRegs = 32;
    localparam int NumTags = 64;

    // Architectural register r sits on tag r after reset, the upper half is free
    localparam int FirstFreeTag = 32;

    // x0 and instructions without a result use this in place of a tag
    localparam SrcTag_t NoTag = 7'h40;

endpackage

//--- logic/LookupIf.sv
`timescale 1ns/100ps

// Source register lookup, purely combinational
interface LookupIf;
    import RenamePkg::*;

    ArchReg_t rs1;
    ArchReg_t rs2;
    PhysTag_t tag1;
    PhysTag_t tag2;
    logic     avail1;
    logic     avail2;

    modport stage (output rs1, rs2, input tag1, avail1, tag2, avail2);

    modport mapTable (input rs1, rs2, output tag1, avail1, tag2, avail2);

endinterface

//--- logic/CommitIf.sv
`timescale 1ns/100ps

// One committed micro-op with a nonzero destination
interface CommitIf;
    import RenamePkg::*;

    logic     valid;
    ArchReg_t rd;
    PhysTag_t tagDst;
    // Committed tag of rd before this commit, about to be released
    PhysTag_t prevTag;

    modport source (output valid, rd, tagDst);
    modport mapTable (input valid, rd, tagDst, output prevTag);
    modport buffer (input valid, rd, tagDst, prevTag);

endinterface

//--- logic/RenameTable.sv
`timescale 1ns/100ps

module RenameTable (
    input  logic                clk,
    input  logic                rst,
    LookupIf.mapTable           lookup,
    CommitIf.mapTable           commit,
    input  logic                issueValid,
    input  RenamePkg::ArchReg_t issueRd,
    input  RenamePkg::PhysTag_t issueTag,
    input  logic                wbValid,
    input  RenamePkg::PhysTag_t wbTag,
    input  logic                mispredict
);
    import RenamePkg::*;

    // Speculative map with a ready bit per register
    PhysTag_t specTag [NumArchRegs];
    logic     specAvail [NumArchRegs];

    // Committed map and its value after this cycle's commit
    PhysTag_t comTag [NumArchRegs];
    PhysTag_t comTagNext [NumArchRegs];

    // Lookups see a writeback in the same cycle as already done
    assign lookup.tag1 = specTag[lookup.rs1];
    assign lookup.tag2 = specTag[lookup.rs2];
    assign lookup.avail1 = specAvail[lookup.rs1] || (wbValid && specTag[lookup.rs1] == wbTag);
    assign lookup.avail2 = specAvail[lookup.rs2] || (wbValid && specTag[lookup.rs2] == wbTag);

    assign commit.prevTag = comTag[commit.rd];

    always_comb begin
        comTagNext = comTag;
        if (commit.valid) begin
            comTagNext[commit.rd] = commit.tagDst;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NumArchRegs; r++) begin
                specTag[r] <= PhysTag_t'(r);
                specAvail[r] <= 1'b1;
                comTag[r] <= PhysTag_t'(r);
            end
        end else begin
            comTag <= comTagNext;
            if (mispredict) begin
                // Committed values are all written back, so everything is ready
                specTag <= comTagNext;
                for (int r = 0; r < NumArchRegs; r++) begin
                    specAvail[r] <= 1'b1;
                end
            end else begin
                for (int r = 0; r < NumArchRegs; r++) begin
                    if (wbValid && specTag[r] == wbTag) begin
                        specAvail[r] <= 1'b1;
                    end
                end
                // New producer overrides any wakeup of the old mapping
                if (issueValid) begin
                    specTag[issueRd] <= issueTag;
                    specAvail[issueRd] <= 1'b0;
                end
            end
        end
    end

    // x0 has no mapping, the rename stage drops such commits
    assert property (@(posedge clk) disable iff (rst) commit.valid |-> commit.rd != '0)
        else $error("Commit to register 0 reached the rename table");

endmodule

//--- logic/TagBuffer.sv
`timescale 1ns/100ps

module TagBuffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                allocReq,
    output RenamePkg::PhysTag_t freeTag,
    output logic                freeAvail,
    CommitIf.buffer             commit,
    input  logic                mispredict
);
    import RenamePkg::*;

    TagState_e state [NumTags];
    TagState_e stateNext [NumTags];

    // Priority search, scanning downwards so the lowest free tag is kept
    always_comb begin
        freeTag = '0;
        freeAvail = 1'b0;
        for (int i = NumTags - 1; i >= 0; i--) begin
            if (state[i] == TagFree) begin
                freeTag = PhysTag_t'(i);
                freeAvail = 1'b1;
            end
        end
    end

    always_comb begin
        stateNext = state;
        if (allocReq) begin
            stateNext[freeTag] = TagSpeculative;
        end
        // Commit goes first so a mispredict in the same cycle keeps its tag
        if (commit.valid) begin
            stateNext[commit.tagDst] = TagCommitted;
            stateNext[commit.prevTag] = TagFree;
        end
        if (mispredict) begin
            for (int i = 0; i < NumTags; i++) begin
                if (stateNext[i] == TagSpeculative) begin
                    stateNext[i] = TagFree;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NumTags; i++) begin
                if (i < FirstFreeTag) begin
                    state[i] <= TagCommitted;
                end else begin
                    state[i] <= TagFree;
                end
            end
        end else begin
            state <= stateNext;
        end
    end

    // Rename must stall rather than request from an empty buffer
    assert property (@(posedge clk) disable iff (rst) allocReq |-> freeAvail)
        else $error("Tag allocated while no tag is free");

    // Only a tag handed out by rename and not yet squashed can retire
    assert property (@(posedge clk) disable iff (rst)
        commit.valid |-> state[commit.tagDst] == TagSpeculative)
        else $error("Commit of tag %0d which is not speculative", commit.tagDst);

endmodule

//--- logic/Rename.sv
`timescale 1ns/100ps

module Rename (
    input  logic                clk,
    input  logic                rst,
    input  logic                inValid,
    input  RenamePkg::ArchReg_t inRs1,
    input  RenamePkg::ArchReg_t inRs2,
    input  RenamePkg::ArchReg_t inRd,
    output logic                stall,
    input  logic                issueStall,
    input  logic                wbValid,
    input  RenamePkg::PhysTag_t wbTag,
    input  logic                comValid,
    input  RenamePkg::ArchReg_t comRd,
    input  RenamePkg::PhysTag_t comTagDst,
    input  logic                branchTaken,
    input  RenamePkg::SqN_t     branchSqN,
    LookupIf.stage              lookup,
    CommitIf.source             commit,
    output logic                allocReq,
    input  RenamePkg::PhysTag_t freeTag,
    input  logic                freeAvail,
    output logic                issueValid,
    output RenamePkg::ArchReg_t issueRd,
    output RenamePkg::PhysTag_t issueTag,
    output logic                outValid,
    output RenamePkg::SrcTag_t  outRs1Tag,
    output logic                outRs1Avail,
    output RenamePkg::SrcTag_t  outRs2Tag,
    output logic                outRs2Avail,
    output RenamePkg::SrcTag_t  outDstTag,
    output RenamePkg::ArchReg_t outRd,
    output RenamePkg::SqN_t     outSqN
);
    import RenamePkg::*;

    logic    rdNeedsTag;
    logic    accept;
    SrcTag_t rs1Tag;
    SrcTag_t rs2Tag;
    SrcTag_t dstTag;
    logic    rs1Avail;
    logic    rs2Avail;
    SqN_t    nextSqN;

    assign rdNeedsTag = inRd != '0;

    assign stall = issueStall || (inValid && rdNeedsTag && !freeAvail) || branchTaken;
    assign accept = inValid && !stall;

    // Only a result register consumes a tag
    assign allocReq = accept && rdNeedsTag;
    assign issueValid = allocReq;
    assign issueRd = inRd;
    assign issueTag = freeTag;

    assign lookup.rs1 = inRs1;
    assign lookup.rs2 = inRs2;

    // x0 is hardwired, never waits on anything
    assign rs1Tag = (inRs1 == '0) ? NoTag : {1'b0, lookup.tag1};
    assign rs2Tag = (inRs2 == '0) ? NoTag : {1'b0, lookup.tag2};
    assign rs1Avail = (inRs1 == '0) || lookup.avail1;
    assign rs2Avail = (inRs2 == '0) || lookup.avail2;
    assign dstTag = rdNeedsTag ? {1'b0, freeTag} : NoTag;

    // Writes to x0 are discarded, so their commits carry no mapping change
    assign commit.valid = comValid && comRd != '0;
    assign commit.rd = comRd;
    assign commit.tagDst = comTagDst;

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
            nextSqN <= '0;
        end else begin
            if (accept) begin
                outValid <= 1'b1;
                outRs1Tag <= rs1Tag;
                outRs1Avail <= rs1Avail;
                outRs2Tag <= rs2Tag;
                outRs2Avail <= rs2Avail;
                outDstTag <= dstTag;
                outRd <= inRd;
                outSqN <= nextSqN;
                nextSqN <= nextSqN + SqN_t'(1);
            end else if (issueStall) begin
                // Held micro-op keeps listening for its operands
                if (wbValid && outRs1Tag == {1'b0, wbTag}) begin
                    outRs1Avail <= 1'b1;
                end
                if (wbValid && outRs2Tag == {1'b0, wbTag}) begin
                    outRs2Avail <= 1'b1;
                end
            end else begin
                outValid <= 1'b0;
            end

            if (branchTaken) begin
                nextSqN <= branchSqN + SqN_t'(1);
                // Squash a held micro-op that is younger than the branch
                if ($signed(outSqN - branchSqN) > 0) begin
                    outValid <= 1'b0;
                end
            end
        end
    end

    // Younger work is gone one edge after the mispredict
    assert property (@(posedge clk) disable iff (rst)
        (branchTaken && outValid && $signed(outSqN - branchSqN) > 0) |=> !outValid)
        else $error("Squashed micro-op %0d still valid after mispredict", $past(outSqN));

endmodule

//--- logic/RenameCore.sv
`timescale 1ns/100ps

module RenameCore (
    input  logic                clk,
    input  logic                rst,
    input  logic                inValid,
    input  RenamePkg::ArchReg_t inRs1,
    input  RenamePkg::ArchReg_t inRs2,
    input  RenamePkg::ArchReg_t inRd,
    output logic                stall,
    input  logic                issueStall,
    input  logic                wbValid,
    input  RenamePkg::PhysTag_t wbTag,
    input  logic                comValid,
    input  RenamePkg::ArchReg_t comRd,
    input  RenamePkg::PhysTag_t comTagDst,
    input  logic                branchTaken,
    input  RenamePkg::SqN_t     branchSqN,
    output logic                outValid,
    output RenamePkg::SrcTag_t  outRs1Tag,
    output logic                outRs1Avail,
    output RenamePkg::SrcTag_t  outRs2Tag,
    output logic                outRs2Avail,
    output RenamePkg::SrcTag_t  outDstTag,
    output RenamePkg::ArchReg_t outRd,
    output RenamePkg::SqN_t     outSqN
);
    import RenamePkg::*;

    logic     allocReq;
    PhysTag_t freeTag;
    logic     freeAvail;
    logic     issueValid;
    ArchReg_t issueRd;
    PhysTag_t issueTag;

    LookupIf lookupBus ();
    CommitIf commitBus ();

    Rename u_rename (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inRs1(inRs1),
        .inRs2(inRs2),
        .inRd(inRd),
        .stall(stall),
        .issueStall(issueStall),
        .wbValid(wbValid),
        .wbTag(wbTag),
        .comValid(comValid),
        .comRd(comRd),
        .comTagDst(comTagDst),
        .branchTaken(branchTaken),
        .branchSqN(branchSqN),
        .lookup(lookupBus.stage),
        .commit(commitBus.source),
        .allocReq(allocReq),
        .freeTag(freeTag),
        .freeAvail(freeAvail),
        .issueValid(issueValid),
        .issueRd(issueRd),
        .issueTag(issueTag),
        .outValid(outValid),
        .outRs1Tag(outRs1Tag),
        .outRs1Avail(outRs1Avail),
        .outRs2Tag(outRs2Tag),
        .outRs2Avail(outRs2Avail),
        .outDstTag(outDstTag),
        .outRd(outRd),
        .outSqN(outSqN)
    );

    RenameTable u_table (
        .clk(clk),
        .rst(rst),
        .lookup(lookupBus.mapTable),
        .commit(commitBus.mapTable),
        .issueValid(issueValid),
        .issueRd(issueRd),
        .issueTag(issueTag),
        .wbValid(wbValid),
        .wbTag(wbTag),
        .mispredict(branchTaken)
    );

    TagBuffer u_tagBuffer (
        .clk(clk),
        .rst(rst),
        .allocReq(allocReq),
        .freeTag(freeTag),
        .freeAvail(freeAvail),
        .commit(commitBus.buffer),
        .mispredict(branchTaken)
    );

endmodule

//--- tests/RenameTb.sv
`timescale 1ns/100ps

module RenameTb;
    import RenamePkg::*;

    localparam int MaxCycles = 1200;
    localparam logic [6:0] NoPhys = 7'h40;

    logic     clk = 1'b0;
    logic     rst;
    logic     inValid;
    ArchReg_t inRs1;
    ArchReg_t inRs2;
    ArchReg_t inRd;
    logic     stall;
    logic     issueStall;
    logic     wbValid;
    PhysTag_t wbTag;
    logic     comValid;
    ArchReg_t comRd;
    PhysTag_t comTagDst;
    logic     branchTaken;
    SqN_t     branchSqN;
    logic     outValid;
    SrcTag_t  outRs1Tag;
    logic     outRs1Avail;
    SrcTag_t  outRs2Tag;
    logic     outRs2Avail;
    SrcTag_t  outDstTag;
    ArchReg_t outRd;
    SqN_t     outSqN;

    // Reference model of both maps and the tag states
    // Tag state 0 is free, 1 speculative and 2 committed
    logic [5:0] modelSpec [32];
    logic       modelAvail [32];
    logic [5:0] modelCom [32];
    int         modelState [64];
    logic [6:0] modelSqN;

    // Expected content of the output register
    logic       expValid;
    logic [6:0] expRs1Tag;
    logic       expRs1Avail;
    logic [6:0] expRs2Tag;
    logic       expRs2Avail;
    logic [6:0] expDstTag;
    logic [4:0] expRd;
    logic [6:0] expSqN;

    logic [31:0] lfsr = 32'd87428;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    RenameCore u_dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MaxCycles) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic checkOutputs();
        checkValue("outValid", 32'(outValid), 32'(expValid));
        if (expValid) begin
            checkValue("outRs1Tag", 32'(outRs1Tag), 32'(expRs1Tag));
            checkValue("outRs1Avail", 32'(outRs1Avail), 32'(expRs1Avail));
            checkValue("outRs2Tag", 32'(outRs2Tag), 32'(expRs2Tag));
            checkValue("outRs2Avail", 32'(outRs2Avail), 32'(expRs2Avail));
            checkValue("outDstTag", 32'(outDstTag), 32'(expDstTag));
            checkValue("outRd", 32'(outRd), 32'(expRd));
            checkValue("outSqN", 32'(outSqN), 32'(expSqN));
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic randReg(output logic [4:0] r);
        r = '0;
        for (int b = 0; b < 5; b++) begin
            lfsr = lfsrStep(lfsr);
            r = {r[3:0], lfsr[0]};
        end
    endtask

    task automatic randNonZero(output logic [4:0] r);
        do begin
            randReg(r);
        end while (r == '0);
    endtask

    function automatic int lowestFree();
        int found;
        found = -1;
        for (int i = 63; i >= 0; i--) begin
            if (modelState[i] == 0) begin
                found = i;
            end
        end
        return found;
    endfunction

    task automatic resetModel();
        for (int r = 0; r < 32; r++) begin
            modelSpec[r] = 6'(r);
            modelAvail[r] = 1'b1;
            modelCom[r] = 6'(r);
        end
        for (int i = 0; i < 64; i++) begin
            modelState[i] = (i < 32) ? 2 : 0;
        end
        modelSqN = '0;
        expValid = 1'b0;
    endtask

    task automatic applyWriteback(input logic wbV, input logic [5:0] wbT);
        for (int r = 0; r < 32; r++) begin
            if (wbV && modelSpec[r] == wbT) begin
                modelAvail[r] = 1'b1;
            end
        end
    endtask

    // One accepted micro-op with an optional writeback in the same cycle
    task automatic renameOp(input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd,
                            input logic wbV, input logic [5:0] wbT);
        logic [5:0] dst;
        inValid = 1'b1;
        inRs1 = rs1;
        inRs2 = rs2;
        inRd = rd;
        wbValid = wbV;
        wbTag = wbT;
        #1;
        checkValue("stall", 32'(stall), 32'd0);
        dst = 6'(lowestFree());
        expValid = 1'b1;
        expRs1Tag = (rs1 == '0) ? NoPhys : {1'b0, modelSpec[rs1]};
        expRs1Avail = (rs1 == '0) || modelAvail[rs1] || (wbV && modelSpec[rs1] == wbT);
        expRs2Tag = (rs2 == '0) ? NoPhys : {1'b0, modelSpec[rs2]};
        expRs2Avail = (rs2 == '0) || modelAvail[rs2] || (wbV && modelSpec[rs2] == wbT);
        expDstTag = (rd == '0) ? NoPhys : {1'b0, dst};
        expRd = rd;
        expSqN = modelSqN;
        @(posedge clk);
        #2;
        applyWriteback(wbV, wbT);
        if (rd != '0) begin
            modelSpec[rd] = dst;
            modelAvail[rd] = 1'b0;
            modelState[dst] = 1;
        end
        modelSqN = modelSqN + 7'd1;
        inValid = 1'b0;
        wbValid = 1'b0;
        checkOutputs();
    endtask

    task automatic writebackOp(input logic [5:0] tag);
        wbValid = 1'b1;
        wbTag = tag;
        @(posedge clk);
        #2;
        applyWriteback(1'b1, tag);
        wbValid = 1'b0;
        expValid = 1'b0;
        checkOutputs();
    endtask

    task automatic commitOp(input logic [4:0] rd, input logic [5:0] tag);
        logic [5:0] prev;
        comValid = 1'b1;
        comRd = rd;
        comTagDst = tag;
        @(posedge clk);
        #2;
        prev = modelCom[rd];
        modelCom[rd] = tag;
        modelState[tag] = 2;
        modelState[prev] = 0;
        comValid = 1'b0;
        expValid = 1'b0;
        checkOutputs();
    endtask

    task automatic mispredictOp(input logic [6:0] sqn);
        branchTaken = 1'b1;
        branchSqN = sqn;
        #1;
        checkValue("stall", 32'(stall), 32'd1);
        @(posedge clk);
        #2;
        for (int r = 0; r < 32; r++) begin
            modelSpec[r] = modelCom[r];
            modelAvail[r] = 1'b1;
        end
        for (int i = 0; i < 64; i++) begin
            if (modelState[i] == 1) begin
                modelState[i] = 0;
            end
        end
        modelSqN = sqn + 7'd1;
        branchTaken = 1'b0;
        expValid = 1'b0;
        checkOutputs();
    endtask

    // Output held by issue while the pending micro-op stays on the inputs
    task automatic holdCycle(input logic wbV, input logic [5:0] wbT);
        issueStall = 1'b1;
        wbValid = wbV;
        wbTag = wbT;
        #1;
        checkValue("stall", 32'(stall), 32'd1);
        @(posedge clk);
        #2;
        applyWriteback(wbV, wbT);
        if (wbV && expRs1Tag == {1'b0, wbT}) begin
            expRs1Avail = 1'b1;
        end
        if (wbV && expRs2Tag == {1'b0, wbT}) begin
            expRs2Avail = 1'b1;
        end
        wbValid = 1'b0;
        checkOutputs();
    endtask

    task automatic testReset();
        checkValue("outValid", 32'(outValid), 32'd0);
        checkValue("stall", 32'(stall), 32'd0);
        renameOp(5'd1, 5'd2, 5'd3, 1'b0, 6'd0);
        renameOp(5'd4, 5'd5, 5'd6, 1'b0, 6'd0);
        renameOp(5'd0, 5'd0, 5'd7, 1'b0, 6'd0);
    endtask

    task automatic testDependency();
        renameOp(5'd3, 5'd6, 5'd8, 1'b0, 6'd0);
        writebackOp(6'd32);
        // x0 sources and destination
        renameOp(5'd3, 5'd0, 5'd0, 1'b0, 6'd0);
        // Same-cycle bypass of tag 33
        renameOp(5'd6, 5'd6, 5'd9, 1'b1, 6'd33);
    endtask

    task automatic testExhaustion();
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        while (lowestFree() >= 0) begin
            randReg(rs1);
            randReg(rs2);
            randNonZero(rd);
            renameOp(rs1, rs2, rd, 1'b0, 6'd0);
        end
        randNonZero(rd);
        inValid = 1'b1;
        inRs1 = 5'd1;
        inRs2 = 5'd2;
        inRd = rd;
        #1;
        checkValue("stall", 32'(stall), 32'd1);
        // Oldest rename retires and releases tag 3
        commitOp(5'd3, 6'd32);
        renameOp(5'd1, 5'd2, rd, 1'b0, 6'd0);
    endtask

    task automatic testMispredict();
        mispredictOp(modelSqN - 7'd3);
        renameOp(5'd3, 5'd4, 5'd5, 1'b0, 6'd0);
    endtask

    task automatic testBackPressure();
        renameOp(5'd5, 5'd3, 5'd10, 1'b0, 6'd0);
        inValid = 1'b1;
        inRs1 = 5'd10;
        inRs2 = 5'd5;
        inRd = 5'd12;
        holdCycle(1'b0, 6'd0);
        holdCycle(1'b1, expRs1Tag[5:0]);
        issueStall = 1'b0;
        renameOp(5'd10, 5'd5, 5'd12, 1'b0, 6'd0);
        // Held micro-op younger than the branch is dropped
        issueStall = 1'b1;
        mispredictOp(modelSqN - 7'd2);
        issueStall = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        inValid = 1'b0;
        inRs1 = '0;
        inRs2 = '0;
        inRd = '0;
        issueStall = 1'b0;
        wbValid = 1'b0;
        wbTag = '0;
        comValid = 1'b0;
        comRd = '0;
        comTagDst = '0;
        branchTaken = 1'b0;
        branchSqN = '0;
        resetModel();
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        testReset();
        testDependency();
        testExhaustion();
        testMispredict();
        testBackPressure();
        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- src.f
logic/RenamePkg.sv
logic/LookupIf.sv
logic/CommitIf.sv
logic/RenameTable.sv
logic/TagBuffer.sv
logic/Rename.sv
logic/RenameCore.sv
tests/RenameTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= RenameTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
